// ==== verilog.f ====
common/demosaic_pkg.sv
window/line_buffer.sv
window/window_5x5.sv
demosaic/bayer_kernel.sv
verilog/frame_ctrl.sv
verilog/position_counter.sv
verilog/raw_to_rgb_top.sv
tests/tb_raw_to_rgb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the demosaic testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_raw_to_rgb -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "ALL CHECKS PASSED" sim.log; then
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1

// ==== tests/tb_raw_to_rgb.sv ====
`timescale 1ns/1ps
module tb_raw_to_rgb
    import demosaic_pkg::*;
();

    typedef pixel_t frame_t [IMG_VDISP][IMG_HDISP];   // One RAW8 frame

    logic        clk;
    logic        rst_n;
    logic        vsync;
    logic        href;
    logic        hsync;
    logic [1:0]  mirror;
    pixel_t      raw;
    logic        post_vsync;
    logic        post_href;
    logic        post_hsync;
    pixel_t      red;
    pixel_t      green;
    pixel_t      blue;

    frame_t      img;                                 // Frame being sent
    logic [23:0] exp_q [$];                           // Expected RGB per driven pixel
    logic [23:0] exp_rgb;
    logic [8:0]  sync_hist;                           // Inputs of the last 3 edges
    int          sent_cnt;
    int          seen_cnt;

    raw_to_rgb_top raw_to_rgb_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .vsync      (vsync),
        .href       (href),
        .hsync      (hsync),
        .mirror     (mirror),
        .raw        (raw),
        .post_vsync (post_vsync),
        .post_href  (post_href),
        .post_hsync (post_hsync),
        .red        (red),
        .green      (green),
        .blue       (blue)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;                        // 4 ns period
    end

    // ----------------------------------------
    // Error handling and compare
    // ----------------------------------------
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual)
            stop_on_error($sformatf("mismatch at %0t ns: %s expected %0d, got %0d",
                                    $time, what, expected, actual));
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic int sample_at(input frame_t f, input int r, input int c);
        if (r < 0 || c < 0)
            return 0;                                 // Above or left of the image
        return int'(f[r][c]);
    endfunction

    function automatic int clamp_byte(input int v);
        if (v < 0)
            return 0;
        if (v > 255)
            return 255;
        return v;
    endfunction

    // RGB for the window whose newest pixel is (r, c); centre is two up and two left
    function automatic logic [23:0] ref_rgb(input frame_t f, input int r, input int c,
                                            input logic [1:0] mir);
        int cr, cc, ctr, h1, v1, h2, v2, dg;
        int est_g, est_h, est_v, est_x;
        int r_row, r_col;
        int red_v, grn_v, blu_v;
        cr  = r - 2;
        cc  = c - 2;
        ctr = sample_at(f, cr, cc);
        h1  = sample_at(f, cr, cc - 1) + sample_at(f, cr, cc + 1);
        v1  = sample_at(f, cr - 1, cc) + sample_at(f, cr + 1, cc);
        h2  = sample_at(f, cr, cc - 2) + sample_at(f, cr, cc + 2);
        v2  = sample_at(f, cr - 2, cc) + sample_at(f, cr + 2, cc);
        dg  = sample_at(f, cr - 1, cc - 1) + sample_at(f, cr - 1, cc + 1)
            + sample_at(f, cr + 1, cc - 1) + sample_at(f, cr + 1, cc + 1);
        est_g = clamp_byte((4 * ctr + 2 * (h1 + v1) - (h2 + v2)) >>> 3);
        est_h = clamp_byte((5 * ctr + 4 * h1 - dg - h2 + (v2 >>> 1)) >>> 3);
        est_v = clamp_byte((5 * ctr + 4 * v1 - dg - v2 + (h2 >>> 1)) >>> 3);
        est_x = clamp_byte((6 * ctr + 2 * dg - (h2 + v2) - ((h2 + v2) >>> 1)) >>> 3);
        case (mir)                                    // Parity of the R sites
            2'd3:    begin r_row = 1; r_col = 1; end
            2'd2:    begin r_row = 1; r_col = 0; end
            2'd0:    begin r_row = 0; r_col = 1; end
            default: begin r_row = 0; r_col = 0; end
        endcase
        if ((r % 2) == r_row && (c % 2) == r_col)
        begin
            red_v = ctr;                              // Red centre
            grn_v = est_g;
            blu_v = est_x;
        end
        else if ((r % 2) != r_row && (c % 2) != r_col)
        begin
            red_v = est_x;                            // Blue centre
            grn_v = est_g;
            blu_v = ctr;
        end
        else if ((r % 2) == r_row)
        begin
            red_v = est_h;                            // Green on a red row
            grn_v = ctr;
            blu_v = est_v;
        end
        else
        begin
            red_v = est_v;                            // Green on a blue row
            grn_v = ctr;
            blu_v = est_h;
        end
        return {red_v[7:0], grn_v[7:0], blu_v[7:0]};
    endfunction

    // ----------------------------------------
    // Frame contents
    // ----------------------------------------
    task automatic fill_flat(input pixel_t v);
        for (int r = 0; r < IMG_VDISP; r++)
            for (int c = 0; c < IMG_HDISP; c++)
                img[r][c] = v;
    endtask

    task automatic fill_random();
        for (int r = 0; r < IMG_VDISP; r++)
            for (int c = 0; c < IMG_HDISP; c++)
                img[r][c] = pixel_t'($urandom_range(0, 255));
    endtask

    task automatic fill_checker();
        for (int r = 0; r < IMG_VDISP; r++)
            for (int c = 0; c < IMG_HDISP; c++)
                img[r][c] = (((r >> 1) + (c >> 1)) % 2 == 1) ? 8'hff : 8'h00;  // 2x2 cells
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic idle_cycles(input int n, input logic v, input logic hs);
        repeat (n)
        begin
            @(negedge clk);
            vsync = v;
            href  = 1'b0;
            hsync = hs;
            raw   = '0;
        end
    endtask

    task automatic send_frame(input logic [1:0] mir);
        mirror = mir;                                 // Pipeline idle by now
        idle_cycles($urandom_range(1, 8), 1'b0, 1'b0);            // Before vsync rises
        idle_cycles($urandom_range(1, 8), 1'b1, 1'b0);            // Before the first line
        for (int r = 0; r < IMG_VDISP; r++)
        begin
            for (int c = 0; c < IMG_HDISP; c++)
            begin
                @(negedge clk);
                vsync = 1'b1;
                href  = 1'b1;
                hsync = 1'b0;
                raw   = img[r][c];
                exp_q.push_back(ref_rgb(img, r, c, mir));
                sent_cnt++;
            end
            idle_cycles($urandom_range(1, 8), 1'b1, 1'b1);        // Line blanking
        end
        idle_cycles($urandom_range(1, 8), 1'b0, 1'b0);            // After vsync falls
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0)
        begin
            if (n == 64)
                stop_on_error("timeout: pixels of the last frame never came out");
            else
            begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    // ----------------------------------------
    // Output monitor
    // ----------------------------------------
    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            sync_hist <= '0;
        else
            sync_hist <= {sync_hist[5:0], vsync, href, hsync};  // Newest in the low bits
    end

    always @(negedge clk)
    begin
        check_value("post_vsync", int'(sync_hist[8]), int'(post_vsync));
        check_value("post_href", int'(sync_hist[7]), int'(post_href));
        check_value("post_hsync", int'(sync_hist[6]), int'(post_hsync));
        if (post_href)
        begin
            if (exp_q.size() == 0)
                stop_on_error("an output pixel appeared with no input pixel behind it");
            else
            begin
                exp_rgb = exp_q.pop_front();
                check_value("red", int'(exp_rgb[23:16]), int'(red));
                check_value("green", int'(exp_rgb[15:8]), int'(green));
                check_value("blue", int'(exp_rgb[7:0]), int'(blue));
                seen_cnt++;
            end
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial
    begin
        void'($urandom(32'h537b));
        rst_n    = 1'b0;
        vsync    = 1'b0;
        href     = 1'b0;
        hsync    = 1'b0;
        mirror   = 2'd0;
        raw      = '0;
        sent_cnt = 0;
        seen_cnt = 0;

        for (int k = 0; k < 16; k++)                  // Outputs held at zero in reset
        begin
            @(negedge clk);
            check_value("red in reset", 0, int'(red));
            check_value("green in reset", 0, int'(green));
            check_value("blue in reset", 0, int'(blue));
        end
        rst_n = 1'b1;
        for (int k = 0; k < 4; k++)
        begin
            @(negedge clk);
            check_value("red after reset", 0, int'(red));
            check_value("green after reset", 0, int'(green));
            check_value("blue after reset", 0, int'(blue));
        end

        // Flat field, full-window pixels keep the level
        fill_flat(8'd147);
        for (int r = 4; r < IMG_VDISP; r++)
            for (int c = 4; c < IMG_HDISP; c++)
                check_value("flat reference", 24'h939393, int'(ref_rgb(img, r, c, 2'd3)));
        send_frame(2'd3);
        wait_drain();

        for (int m = 0; m < 4; m++)                   // Every Bayer phase
        begin
            fill_random();
            send_frame(m[1:0]);
            wait_drain();
        end

        fill_checker();                               // Estimates overshoot both ends
        send_frame(2'd1);
        wait_drain();

        fill_random();                                // Back to back, no drain between
        send_frame(2'd2);
        fill_random();
        send_frame(2'd2);
        wait_drain();

        if (exp_q.size() == 0 && seen_cnt == sent_cnt)
        begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
        else
            stop_on_error("some driven pixels never reached the output");
    end

endmodule

// ==== verilog/raw_to_rgb_top.sv ====
`timescale 1ns/1ps
module raw_to_rgb_top
    import demosaic_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       vsync,
    input  logic       href,
    input  logic       hsync,
    input  logic [1:0] mirror,
    input  pixel_t     raw,
    output logic       post_vsync,
    output logic       post_href,
    output logic       post_hsync,
    output pixel_t     red,
    output pixel_t     green,
    output pixel_t     blue
);

    logic    line_end;
    logic    frame_start;
    row_t    row;                                     // Position of the pixel on raw
    col_t    col;
    window_t win;
    logic    win_valid;

    // ----------------------------------------
    // Framing and position
    // ----------------------------------------
    frame_ctrl frame_ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .vsync       (vsync),
        .href        (href),
        .hsync       (hsync),
        .line_end    (line_end),
        .frame_start (frame_start),
        .post_vsync  (post_vsync),
        .post_href   (post_href),
        .post_hsync  (post_hsync)
    );

    position_counter position_counter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .href        (href),
        .line_end    (line_end),
        .frame_start (frame_start),
        .row         (row),
        .col         (col)
    );

    // ----------------------------------------
    // Pixel path
    // ----------------------------------------
    window_5x5 window_5x5_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .href      (href),
        .raw       (raw),
        .row       (row),
        .col       (col),
        .win       (win),
        .win_valid (win_valid)
    );

    bayer_kernel bayer_kernel_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .win       (win),
        .win_valid (win_valid),
        .row       (row),
        .col       (col),
        .mirror    (mirror),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

endmodule

// ==== verilog/position_counter.sv ====
`timescale 1ns/1ps
module position_counter
    import demosaic_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic href,
    input  logic line_end,
    input  logic frame_start,
    output row_t row,
    output col_t col
);

    // ----------------------------------------
    // Column of the pixel now on raw
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            col <= '0;
        else if (href)
        begin
            if (col == col_t'(IMG_HDISP - 1))
                col <= '0;                            // Ready for the next line
            else
                col <= col + 1'b1;
        end
        else if (line_end)
            col <= '0;
    end

    // ----------------------------------------
    // Row of the pixel now on raw
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            row <= '0;
        else if (frame_start)
            row <= '0;                                // New frame starts at the top
        else if (line_end)
        begin
            if (row == row_t'(IMG_VDISP - 1))
                row <= '0;
            else
                row <= row + 1'b1;
        end
    end

    // Previous frame closed after exactly IMG_VDISP lines
    a_frame_lines: assert property (@(posedge clk) disable iff (!rst_n)
        frame_start |-> row == '0);
    // A full line has wrapped the column before the tracker closes it
    a_col_wrapped: assert property (@(posedge clk) disable iff (!rst_n)
        line_end |-> col == '0);

endmodule

// ==== verilog/frame_ctrl.sv ====
`timescale 1ns/1ps
module frame_ctrl
    import demosaic_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic vsync,
    input  logic href,
    input  logic hsync,
    output logic line_end,
    output logic frame_start,
    output logic post_vsync,
    output logic post_href,
    output logic post_hsync
);

    frame_state_t                 state;
    frame_state_t                 state_nxt;
    logic                         vsync_q;            // Previous vsync for edge detect
    logic [$clog2(IMG_HDISP):0]   run_len;            // Length of current href pulse
    logic [PIPE_LATENCY-1:0]      vsync_dly;
    logic [PIPE_LATENCY-1:0]      href_dly;
    logic [PIPE_LATENCY-1:0]      hsync_dly;

    // ----------------------------------------
    // Line tracking FSM
    // ----------------------------------------
    always_comb
    begin
        state_nxt = state;
        case (state)
            FRAME_IDLE:
                if (vsync && href)
                    state_nxt = LINE_ACTIVE;          // First line of the frame
            LINE_ACTIVE:
                if (!href)
                    state_nxt = vsync ? LINE_GAP : FRAME_IDLE;
            LINE_GAP:
                if (!vsync)
                    state_nxt = FRAME_IDLE;           // Frame over
                else if (href)
                    state_nxt = LINE_ACTIVE;
            default:
                state_nxt = FRAME_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= FRAME_IDLE;
            vsync_q <= 1'b0;
            run_len <= '0;
        end
        else
        begin
            state   <= state_nxt;
            vsync_q <= vsync;
            run_len <= href ? run_len + 1'b1 : '0;    // Cleared once the line closes
        end
    end

    assign line_end    = (state == LINE_ACTIVE) && !href;   // First idle cycle after a line
    assign frame_start = vsync && !vsync_q;                 // First cycle of vsync

    // ----------------------------------------
    // Sync delay matched to the pixel path
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vsync_dly <= '0;
            href_dly  <= '0;
            hsync_dly <= '0;
        end
        else
        begin
            vsync_dly <= {vsync_dly[PIPE_LATENCY-2:0], vsync};
            href_dly  <= {href_dly[PIPE_LATENCY-2:0], href};
            hsync_dly <= {hsync_dly[PIPE_LATENCY-2:0], hsync};
        end
    end

    assign post_vsync = vsync_dly[PIPE_LATENCY-1];
    assign post_href  = href_dly[PIPE_LATENCY-1];
    assign post_hsync = hsync_dly[PIPE_LATENCY-1];

    // Pixels only come inside a frame
    a_href_in_frame: assert property (@(posedge clk) disable iff (!rst_n) href |-> vsync);
    // Line never runs past the image width
    a_line_not_long: assert property (@(posedge clk) disable iff (!rst_n)
        href |-> run_len < IMG_HDISP);
    // Line never ends early
    a_line_not_short: assert property (@(posedge clk) disable iff (!rst_n)
        line_end |-> run_len == IMG_HDISP);

endmodule

// ==== demosaic/bayer_kernel.sv ====
`timescale 1ns/1ps
module bayer_kernel
    import demosaic_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  window_t    win,
    input  logic       win_valid,
    input  row_t       row,
    input  col_t       col,
    input  logic [1:0] mirror,
    output pixel_t     red,
    output pixel_t     green,
    output pixel_t     blue
);

    typedef logic signed [13:0] acc_t;                // Holds every kernel sum

    function automatic acc_t ext(input pixel_t p);
        return acc_t'({6'b0, p});
    endfunction

    function automatic pixel_t clamp8(input acc_t v);
        if (v < 0)
            return 8'h00;
        else if (v > 255)
            return 8'hff;
        return v[7:0];
    endfunction

    logic [1:0] par_q;                                // {row odd, col odd} aligned to win
    logic [1:0] r_par;                                // Parity of the R sites
    acc_t       c, up1, dn1, lf1, rt1, up2, dn2, lf2, rt2;
    acc_t       diag, n1, n2, h2, v2;
    acc_t       g_raw, h_raw, v_raw, x_raw;
    pixel_t     c_q, g_q, h_q, v_q, x_q;
    logic [1:0] site_q;                               // Centre parity relative to R
    logic       valid_q;

    // ----------------------------------------
    // Window taps
    // ----------------------------------------
    assign c    = ext(win[2][2]);
    assign up1  = ext(win[3][2]);
    assign dn1  = ext(win[1][2]);
    assign lf1  = ext(win[2][3]);
    assign rt1  = ext(win[2][1]);
    assign up2  = ext(win[4][2]);
    assign dn2  = ext(win[0][2]);
    assign lf2  = ext(win[2][4]);
    assign rt2  = ext(win[2][0]);
    assign diag = ext(win[1][1]) + ext(win[1][3]) + ext(win[3][1]) + ext(win[3][3]);
    assign n1   = up1 + dn1 + lf1 + rt1;
    assign h2   = lf2 + rt2;
    assign v2   = up2 + dn2;
    assign n2   = h2 + v2;

    // ----------------------------------------
    // Colour estimates
    // ----------------------------------------
    assign g_raw = ((c <<< 2) + (n1 <<< 1) - n2) >>> 3;                   // G at R or B
    assign h_raw = ((c <<< 2) + c + ((lf1 + rt1) <<< 2) - diag - h2
                   + (v2 >>> 1)) >>> 3;                                    // Row colour at G
    assign v_raw = ((c <<< 2) + c + ((up1 + dn1) <<< 2) - diag - v2
                   + (h2 >>> 1)) >>> 3;                                    // Column colour at G
    assign x_raw = ((c <<< 2) + (c <<< 1) + (diag <<< 1) - n2
                   - (n2 >>> 1)) >>> 3;                                    // B at R and R at B

    // Bayer phase
    always_comb
    begin
        case (mirror)
            2'd3:    r_par = 2'b11;
            2'd2:    r_par = 2'b10;
            2'd0:    r_par = 2'b01;
            default: r_par = 2'b00;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            par_q   <= 2'b00;
            valid_q <= 1'b0;
        end
        else
        begin
            par_q   <= {row[0], col[0]};              // Same cycle as the window register
            valid_q <= win_valid;
        end
    end

    // ----------------------------------------
    // Compute stage
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (win_valid)
        begin
            c_q    <= win[2][2];
            g_q    <= clamp8(g_raw);
            h_q    <= clamp8(h_raw);
            v_q    <= clamp8(v_raw);
            x_q    <= clamp8(x_raw);
            site_q <= par_q ^ r_par;                  // 00 R, 11 B, 01 G on R row
        end
    end

    // ----------------------------------------
    // Output stage
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end
        else if (valid_q)
        begin
            case (site_q)
                2'b00:                                // Centre red
                begin
                    red   <= c_q;
                    green <= g_q;
                    blue  <= x_q;
                end
                2'b11:                                // Centre blue
                begin
                    red   <= x_q;
                    green <= g_q;
                    blue  <= c_q;
                end
                2'b01:                                // Green between reds
                begin
                    red   <= h_q;
                    green <= c_q;
                    blue  <= v_q;
                end
                default:                              // Green between blues
                begin
                    red   <= v_q;
                    green <= c_q;
                    blue  <= h_q;
                end
            endcase
        end
    end

endmodule

// ==== window/window_5x5.sv ====
`timescale 1ns/1ps
module window_5x5
    import demosaic_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    href,
    input  pixel_t  raw,
    input  row_t    row,
    input  col_t    col,
    output window_t win,
    output logic    win_valid
);

    pixel_t tap [5];                                  // Column samples for rows r down to r-4

    assign tap[0] = raw;                              // Newest row comes straight in

    // ----------------------------------------
    // Line buffer chain
    // ----------------------------------------
    for (genvar k = 0; k < 4; k++)
    begin : g_lb
        line_buffer line_buffer_i (
            .clk   (clk),
            .wr_en (href),
            .col   (col),
            .din   (tap[k]),                          // Pass the older row down the chain
            .dout  (tap[k+1])
        );
    end

    // ----------------------------------------
    // 5x5 shift array with edge masking
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (href)
        begin
            for (int i = 0; i < 5; i++)
            begin
                // Rows above the frame top read as zero
                win[i][0] <= (row < i) ? '0 : tap[i];
                for (int j = 1; j < 5; j++)
                begin
                    // Columns left of the image read as zero
                    win[i][j] <= (col < j) ? '0 : win[i][j-1];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            win_valid <= 1'b0;
        else
            win_valid <= href;                        // Window updated this cycle
    end

endmodule

// ==== window/line_buffer.sv ====
`timescale 1ns/1ps
module line_buffer
    import demosaic_pkg::*;
(
    input  logic   clk,
    input  logic   wr_en,
    input  col_t   col,
    input  pixel_t din,
    output pixel_t dout
);

    pixel_t mem [0:IMG_HDISP-1];                      // One image line

    // Old sample of this column from the previous line
    assign dout = mem[col];

    // New sample replaces it at the same edge
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[col] <= din;
    end

endmodule

// ==== common/demosaic_pkg.sv ====
package demosaic_pkg;

    // ----------------------------------------
    // Image geometry
    // ----------------------------------------
    localparam int IMG_HDISP    = 32;                  // Active pixels per line
    localparam int IMG_VDISP    = 16;                  // Active lines per frame
    localparam int COL_W        = $clog2(IMG_HDISP);   // Column index width
    localparam int ROW_W        = $clog2(IMG_VDISP);   // Row index width

    // Window register, kernel compute and kernel output stages
    localparam int PIPE_LATENCY = 3;

    // ----------------------------------------
    // Data types
    // ----------------------------------------
    typedef logic [7:0]       pixel_t;                 // One RAW8 sample or colour channel
    typedef logic [COL_W-1:0] col_t;                   // Column of a pixel
    typedef logic [ROW_W-1:0] row_t;                   // Row of a pixel

    // Element [i][j] lies i rows above and j columns left of the newest pixel
    // and the centre sits at [2][2]
    typedef pixel_t [4:0][4:0] window_t;               // 200 bits

    // ----------------------------------------
    // Frame tracker
    // ----------------------------------------
    typedef enum logic [1:0] {
        FRAME_IDLE,                                    // Between frames
        LINE_ACTIVE,                                   // Inside an href pulse
        LINE_GAP                                       // Inside vsync between lines
    } frame_state_t;

endpackage
